/* hdl/clockDisplay_cfg.svh */
`ifndef CLOCKDISPLAY_CFG_SVH
`define CLOCKDISPLAY_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Video timing, 640x480 at one pixel per clock
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

////////////////////////////////////////////////////////////////////////////
// Layout geometry
`define CELL_W 32 // Digit cell width
`define CELL_H 64 // Digit cell height
`define ROW_DATE_Y 64
`define ROW_TIME_Y 192
`define ROW_TIMER_Y 320
`define COL_X0 96 // Tens of first pair
`define COL_X1 128
`define COL_X2 192
`define COL_X3 224
`define COL_X4 288
`define COL_X5 320
`define SEP_X0 160 // Colon or slash cells
`define SEP_X1 256
`define DIV_X0 384 // Divider stripe, inclusive
`define DIV_X1 415
`define ALARM_X 448 // Alarm box, one cell wide and square
`define ALARM_Y 384

////////////////////////////////////////////////////////////////////////////
// Palette, 4 bits per channel RGB
`define COLOR_BG 12'h000
`define COLOR_FG 12'h0F0
`define COLOR_SEP 12'hFF0
`define COLOR_DIV 12'h00F
`define COLOR_ALARM 12'hF00

`define PIPE_DEPTH 3 // Counter to registered VGA output

`endif

/* hdl/clockDisplayPkg.sv */
`default_nettype none

package clockDisplayPkg;

	// What a pixel belongs to, decided by the layout stage
	typedef enum logic [2:0]
	{
		kindBlank, // Outside visible area
		kindBackground,
		kindDigit,
		kindColon,
		kindSlash,
		kindDivider,
		kindAlarm
	} regionKindE;

	// Register block field select
	typedef enum logic [3:0]
	{
		fieldYear,
		fieldMonth,
		fieldDay,
		fieldHour,
		fieldMinute,
		fieldSecond,
		fieldTimerHour,
		fieldTimerMinute,
		fieldTimerSecond,
		fieldAlarm
	} clockFieldE;

	typedef struct packed
	{
		clockFieldE field;
		logic [7:0] value; // BCD byte, bit 0 only for alarm
	} regWriteT;

	// Displayed values, rows top to bottom
	typedef struct packed
	{
		logic [7:0] year;
		logic [7:0] month;
		logic [7:0] day;
		logic [7:0] hour;
		logic [7:0] minute;
		logic [7:0] second;
		logic [7:0] timerHour;
		logic [7:0] timerMinute;
		logic [7:0] timerSecond;
		logic alarm;
	} clockStateT;

	typedef struct packed
	{
		logic [9:0] x;
		logic [9:0] y;
		logic hSync; // Active low
		logic vSync; // Active low
	} pixelPosT;

	typedef struct packed
	{
		regionKindE kind;
		logic [3:0] digit; // BCD nibble for digit cells
		logic [4:0] localX; // u inside the cell
		logic [5:0] localY; // v inside the cell
		logic hSync;
		logic vSync;
	} regionT;

	typedef struct packed
	{
		regionKindE kind;
		logic lit;
		logic hSync;
		logic vSync;
	} glyphT;

	typedef struct packed
	{
		logic [11:0] color;
		logic hSync;
		logic vSync;
	} vgaOutT;

endpackage

`default_nettype wire

/* hdl/vgaTiming.sv */
`timescale 1ns/1ns
`default_nettype none
`include "clockDisplay_cfg.svh"

module vgaTiming
(
	input wire CLK,
	input wire reset,
	output clockDisplayPkg::pixelPosT pos,
	output logic vBlank
);

	logic [9:0] hCount; // Pixel in line
	logic [9:0] vCount; // Line in frame
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == 10'(`H_TOTAL - 1));
	assign frameEnd = (vCount == 10'(`V_TOTAL - 1));

	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 10'd1;

			// Line counter steps once per wrapped line
			if (lineEnd)
			begin
				if (frameEnd)
					vCount <= '0;
				else
					vCount <= vCount + 10'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sync windows follow the front porch
	assign pos.x = hCount;
	assign pos.y = vCount;
	assign pos.hSync = ~((hCount >= 10'(`H_VISIBLE + `H_FRONT)) &&
		(hCount < 10'(`H_VISIBLE + `H_FRONT + `H_SYNC)));
	assign pos.vSync = ~((vCount >= 10'(`V_VISIBLE + `V_FRONT)) &&
		(vCount < 10'(`V_VISIBLE + `V_FRONT + `V_SYNC)));

	assign vBlank = (vCount >= 10'(`V_VISIBLE)); // Whole lines below the picture

endmodule

`default_nettype wire

/* hdl/clockRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module clockRegs
(
	input wire CLK,
	input wire reset,
	input wire writeValid,
	input wire clockDisplayPkg::regWriteT writeData,
	output logic writeReady,
	input wire vBlank,
	output clockDisplayPkg::clockStateT state
);

	// Only take writes between frames so a frame never tears
	assign writeReady = vBlank;

	always_ff @(posedge CLK)
	begin
		if (reset)
			state <= '0;
		else if (writeValid && writeReady)
		begin
			case (writeData.field)
				clockDisplayPkg::fieldYear:
					state.year <= writeData.value;
				clockDisplayPkg::fieldMonth:
					state.month <= writeData.value;
				clockDisplayPkg::fieldDay:
					state.day <= writeData.value;
				clockDisplayPkg::fieldHour:
					state.hour <= writeData.value;
				clockDisplayPkg::fieldMinute:
					state.minute <= writeData.value;
				clockDisplayPkg::fieldSecond:
					state.second <= writeData.value;
				clockDisplayPkg::fieldTimerHour:
					state.timerHour <= writeData.value;
				clockDisplayPkg::fieldTimerMinute:
					state.timerMinute <= writeData.value;
				clockDisplayPkg::fieldTimerSecond:
					state.timerSecond <= writeData.value;
				clockDisplayPkg::fieldAlarm:
					state.alarm <= writeData.value[0]; // Flag only
				default:
					state <= state; // Unused codes ignored
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/screenLayout.sv */
`timescale 1ns/1ns
`default_nettype none
`include "clockDisplay_cfg.svh"

module screenLayout
(
	input wire CLK,
	input wire reset,
	input wire clockDisplayPkg::pixelPosT pos,
	input wire clockDisplayPkg::clockStateT state,
	output clockDisplayPkg::regionT region
);

	// Eight cells per row, left to right, separators at 2 and 5
	localparam logic [9:0] cellX [8] = '{10'(`COL_X0), 10'(`COL_X1), 10'(`SEP_X0),
		10'(`COL_X2), 10'(`COL_X3), 10'(`SEP_X1), 10'(`COL_X4), 10'(`COL_X5)};
	localparam logic [7:0] cellIsSep = 8'b0010_0100;
	localparam logic [2:0] digitOf [8] = '{3'd0, 3'd1, 3'd0, 3'd2, 3'd3, 3'd0, 3'd4, 3'd5};

	logic visible;
	logic alarmHit;
	logic dividerHit;
	logic inRow;
	logic [1:0] rowSel; // 0 date, 1 time, 2 timer
	logic [9:0] rowTop;
	logic [9:0] rowOffset;
	logic cellHit;
	logic [2:0] cellSel;
	logic [9:0] cellOffset;
	logic [7:0] stateBytes [9];
	logic [3:0] byteIdx;
	logic [7:0] pairByte;
	logic [3:0] nibble;
	clockDisplayPkg::regionT regionNext;

	assign visible = (pos.x < 10'(`H_VISIBLE)) && (pos.y < 10'(`V_VISIBLE));
	assign alarmHit = state.alarm &&
		(pos.x >= 10'(`ALARM_X)) && (pos.x < 10'(`ALARM_X + `CELL_W)) &&
		(pos.y >= 10'(`ALARM_Y)) && (pos.y < 10'(`ALARM_Y + `CELL_W));
	assign dividerHit = (pos.x >= 10'(`DIV_X0)) && (pos.x <= 10'(`DIV_X1));

	////////////////////////////////////////////////////////////////////////////
	// Row decode
	always_comb
	begin
		inRow = 1'b1;
		rowSel = 2'd0;
		rowTop = 10'(`ROW_DATE_Y);
		if ((pos.y >= 10'(`ROW_DATE_Y)) && (pos.y < 10'(`ROW_DATE_Y + `CELL_H)))
			rowSel = 2'd0;
		else if ((pos.y >= 10'(`ROW_TIME_Y)) && (pos.y < 10'(`ROW_TIME_Y + `CELL_H)))
		begin
			rowSel = 2'd1;
			rowTop = 10'(`ROW_TIME_Y);
		end
		else if ((pos.y >= 10'(`ROW_TIMER_Y)) && (pos.y < 10'(`ROW_TIMER_Y + `CELL_H)))
		begin
			rowSel = 2'd2;
			rowTop = 10'(`ROW_TIMER_Y);
		end
		else
			inRow = 1'b0;
	end
	assign rowOffset = pos.y - rowTop;

	// Column decode, cells never overlap
	always_comb
	begin
		cellHit = 1'b0;
		cellSel = 3'd0;
		for (int i = 0; i < 8; i++)
		begin
			if ((pos.x >= cellX[i]) && (pos.x < cellX[i] + 10'(`CELL_W)))
			begin
				cellHit = 1'b1;
				cellSel = 3'(i);
			end
		end
	end
	assign cellOffset = pos.x - cellX[cellSel];

	// Byte index is row times three plus pair
	assign stateBytes = '{state.year, state.month, state.day, state.hour, state.minute,
		state.second, state.timerHour, state.timerMinute, state.timerSecond};
	assign byteIdx = 4'(rowSel) * 4'd3 + 4'(digitOf[cellSel][2:1]);
	assign pairByte = stateBytes[byteIdx];
	assign nibble = digitOf[cellSel][0] ? pairByte[3:0] : pairByte[7:4]; // Odd is units

	////////////////////////////////////////////////////////////////////////////
	// Priority: blank, alarm, divider, row cells, background
	always_comb
	begin
		regionNext.digit = nibble;
		regionNext.localX = cellOffset[4:0];
		regionNext.localY = rowOffset[5:0];
		regionNext.hSync = pos.hSync;
		regionNext.vSync = pos.vSync;
		if (!visible)
			regionNext.kind = clockDisplayPkg::kindBlank;
		else if (alarmHit)
			regionNext.kind = clockDisplayPkg::kindAlarm;
		else if (dividerHit)
			regionNext.kind = clockDisplayPkg::kindDivider;
		else if (inRow && cellHit && !cellIsSep[cellSel])
			regionNext.kind = clockDisplayPkg::kindDigit;
		else if (inRow && cellHit)
			regionNext.kind = (rowSel == 2'd0) ? clockDisplayPkg::kindSlash :
				clockDisplayPkg::kindColon; // Date row uses slashes
		else
			regionNext.kind = clockDisplayPkg::kindBackground;
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			region <= '{kind: clockDisplayPkg::kindBlank, hSync: 1'b1, vSync: 1'b1,
				default: '0};
		else
			region <= regionNext;
	end

endmodule

`default_nettype wire

/* hdl/sevenSegGlyph.sv */
`timescale 1ns/1ns
`default_nettype none

module sevenSegGlyph
(
	input wire CLK,
	input wire reset,
	input wire clockDisplayPkg::regionT region,
	output clockDisplayPkg::glyphT glyph
);

	logic [5:0] u; // Widened local column
	logic [5:0] v;
	logic [6:0] segOn; // a..g, a is MSB
	logic [6:0] segHit;
	logic [6:0] slashSum;
	logic lit;

	function automatic logic inSpan(input logic [5:0] val, input logic [5:0] lo,
		input logic [5:0] hi);
		return (val >= lo) && (val <= hi);
	endfunction

	assign u = {1'b0, region.localX};
	assign v = region.localY;

	// Standard segment sets, nibbles above 9 stay dark
	always_comb
	begin
		case (region.digit)
			4'd0: segOn = 7'b1111110;
			4'd1: segOn = 7'b0110000;
			4'd2: segOn = 7'b1101101;
			4'd3: segOn = 7'b1111001;
			4'd4: segOn = 7'b0110011;
			4'd5: segOn = 7'b1011011;
			4'd6: segOn = 7'b1011111;
			4'd7: segOn = 7'b1110000;
			4'd8: segOn = 7'b1111111;
			4'd9: segOn = 7'b1111011;
			default: segOn = 7'b0000000;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Segment rectangles in cell coordinates
	assign segHit[6] = inSpan(v, 6'd0, 6'd5) && inSpan(u, 6'd4, 6'd27); // a
	assign segHit[5] = inSpan(u, 6'd26, 6'd31) && inSpan(v, 6'd4, 6'd31); // b
	assign segHit[4] = inSpan(u, 6'd26, 6'd31) && inSpan(v, 6'd32, 6'd59); // c
	assign segHit[3] = inSpan(v, 6'd58, 6'd63) && inSpan(u, 6'd4, 6'd27); // d
	assign segHit[2] = inSpan(u, 6'd0, 6'd5) && inSpan(v, 6'd32, 6'd59); // e
	assign segHit[1] = inSpan(u, 6'd0, 6'd5) && inSpan(v, 6'd4, 6'd31); // f
	assign segHit[0] = inSpan(v, 6'd29, 6'd34) && inSpan(u, 6'd4, 6'd27); // g

	// 2u + v, a two pixel wide diagonal at 62 and 63
	assign slashSum = {u, 1'b0} + {1'b0, v};

	always_comb
	begin
		case (region.kind)
			clockDisplayPkg::kindDigit:
				lit = |(segOn & segHit);
			clockDisplayPkg::kindColon:
				lit = inSpan(u, 6'd12, 6'd19) &&
					(inSpan(v, 6'd16, 6'd23) || inSpan(v, 6'd40, 6'd47)); // Two dots
			clockDisplayPkg::kindSlash:
				lit = (slashSum[6:1] == 6'd31);
			clockDisplayPkg::kindDivider, clockDisplayPkg::kindAlarm:
				lit = 1'b1; // Solid fill
			default:
				lit = 1'b0;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			glyph <= '{kind: clockDisplayPkg::kindBlank, lit: 1'b0, hSync: 1'b1, vSync: 1'b1};
		else
			glyph <= '{kind: region.kind, lit: lit, hSync: region.hSync, vSync: region.vSync};
	end

endmodule

`default_nettype wire

/* hdl/pixelMixer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "clockDisplay_cfg.svh"

module pixelMixer
(
	input wire CLK,
	input wire reset,
	input wire clockDisplayPkg::glyphT glyph,
	output clockDisplayPkg::vgaOutT vgaOut
);

	logic [11:0] color;

	// Palette lookup by region kind
	always_comb
	begin
		case (glyph.kind)
			clockDisplayPkg::kindDigit:
				color = glyph.lit ? `COLOR_FG : `COLOR_BG;
			clockDisplayPkg::kindColon, clockDisplayPkg::kindSlash:
				color = glyph.lit ? `COLOR_SEP : `COLOR_BG;
			clockDisplayPkg::kindDivider:
				color = glyph.lit ? `COLOR_DIV : `COLOR_BG;
			clockDisplayPkg::kindAlarm:
				color = glyph.lit ? `COLOR_ALARM : `COLOR_BG;
			clockDisplayPkg::kindBackground:
				color = `COLOR_BG;
			default:
				color = 12'h000; // Blanking must be black
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (reset)
			vgaOut <= '{color: 12'h000, hSync: 1'b1, vSync: 1'b1}; // Syncs idle high
		else
			vgaOut <= '{color: color, hSync: glyph.hSync, vSync: glyph.vSync};
	end

endmodule

`default_nettype wire

/* hdl/clockDisplay.sv */
`timescale 1ns/1ns
`default_nettype none

module clockDisplay
(
	input wire CLK,
	input wire reset,
	input wire writeValid,
	input wire clockDisplayPkg::regWriteT writeData,
	output wire writeReady,
	output wire clockDisplayPkg::vgaOutT vgaOut
);

	clockDisplayPkg::pixelPosT pos;
	logic vBlank;
	clockDisplayPkg::clockStateT state;
	clockDisplayPkg::regionT region; // Stage 1
	clockDisplayPkg::glyphT glyph; // Stage 2

	vgaTiming vgaTiming_i
	(
		.CLK(CLK),
		.reset(reset),
		.pos(pos),
		.vBlank(vBlank)
	);

	clockRegs clockRegs_i
	(
		.CLK(CLK),
		.reset(reset),
		.writeValid(writeValid),
		.writeData(writeData),
		.writeReady(writeReady),
		.vBlank(vBlank),
		.state(state)
	);

	screenLayout screenLayout_i
	(
		.CLK(CLK),
		.reset(reset),
		.pos(pos),
		.state(state),
		.region(region)
	);

	sevenSegGlyph sevenSegGlyph_i
	(
		.CLK(CLK),
		.reset(reset),
		.region(region),
		.glyph(glyph)
	);

	pixelMixer pixelMixer_i
	(
		.CLK(CLK),
		.reset(reset),
		.glyph(glyph),
		.vgaOut(vgaOut)
	);

endmodule

`default_nettype wire

/* verification/clockDisplayTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "clockDisplay_cfg.svh"

module clockDisplayTb;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL; // Pixels per frame
	localparam int RESET_CYCLES = 4;
	localparam int VECTOR_WORDS = 256;

	// One register write and the frame in which it is offered
	typedef struct packed
	{
		logic [7:0] frame;
		clockDisplayPkg::regWriteT write;
	} plannedWriteT;

	// Expected color of one pixel in one frame
	typedef struct packed
	{
		logic [7:0] frame;
		logic [9:0] x;
		logic [9:0] y;
		logic [11:0] color;
	} pixelCheckT;

	logic CLK;
	logic reset;
	logic writeValid;
	clockDisplayPkg::regWriteT writeData;
	wire writeReady;
	wire clockDisplayPkg::vgaOutT vgaOut;

	logic [15:0] vectorWords [VECTOR_WORDS]; // Raw records, five words each
	plannedWriteT writes [$];
	pixelCheckT checks [$];
	int cycle = 0; // Edges since reset release
	int cycleLimit = 0;
	int watchCount = 0;

	clockDisplay clockDisplay_i
	(
		.CLK(CLK),
		.reset(reset),
		.writeValid(writeValid),
		.writeData(writeData),
		.writeReady(writeReady),
		.vgaOut(vgaOut)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#50 CLK = ~CLK; // 100 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure and compare helpers

	task automatic failNow();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at %0t", $time);
	endtask

	task automatic checkColor(input clockDisplayPkg::vgaOutT got, input logic [11:0] expected,
		input int x, input int y);
		if (got.color !== expected)
		begin
			$display("CHECK FAILED t=%0t vgaOut.color at (%0d,%0d) got %h expected %h",
				$time, x, y, got.color, expected);
			failNow();
		end
	endtask

	task automatic checkSync(input clockDisplayPkg::vgaOutT got, input logic hExpected,
		input logic vExpected);
		if (got.hSync !== hExpected)
		begin
			$display("CHECK FAILED t=%0t vgaOut.hSync got %b expected %b",
				$time, got.hSync, hExpected);
			failNow();
		end
		else if (got.vSync !== vExpected)
		begin
			$display("CHECK FAILED t=%0t vgaOut.vSync got %b expected %b",
				$time, got.vSync, vExpected);
			failNow();
		end
	endtask

	task automatic checkReady(input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED t=%0t writeReady got %b expected %b", $time, got, expected);
			failNow();
		end
	endtask

	// Splits the vector file into write and pixel queues
	task automatic loadVectors(output int lastFrame);
		int idx;
		plannedWriteT w;
		pixelCheckT c;
		idx = 0;
		lastFrame = 0;
		for (int i = 0; i < VECTOR_WORDS; i++)
			vectorWords[i] = '0; // Zero kind ends the list
		$readmemh("verification/clockDisplay_golden.txt", vectorWords);
		while ((idx + 4 < VECTOR_WORDS) && (vectorWords[idx] != 16'h0))
		begin
			if (vectorWords[idx] == 16'h1)
			begin
				w.frame = vectorWords[idx + 1][7:0];
				w.write.field = clockDisplayPkg::clockFieldE'(vectorWords[idx + 2][3:0]);
				w.write.value = vectorWords[idx + 3][7:0];
				writes.push_back(w);
			end
			else if (vectorWords[idx] == 16'h2)
			begin
				c.frame = vectorWords[idx + 1][7:0];
				c.x = vectorWords[idx + 2][9:0];
				c.y = vectorWords[idx + 3][9:0];
				c.color = vectorWords[idx + 4][11:0];
				checks.push_back(c);
				if (int'(c.frame) > lastFrame)
					lastFrame = int'(c.frame);
			end
			else
			begin
				$display("Vector file has unknown record kind %h at word %0d",
					vectorWords[idx], idx);
				failNow();
			end
			idx = idx + 5;
		end
		if (checks.size() == 0)
		begin
			$display("Vector file holds no pixel checks");
			failNow();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Watchdog

	always @(posedge CLK)
	begin
		if (!reset)
		begin
			watchCount <= watchCount + 1;
			if ((cycleLimit > 0) && (watchCount >= cycleLimit))
			begin
				$display("Timeout after %0d cycles without reaching the end of the test",
					watchCount);
				failNow();
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence, drive and sample on the falling edge

	initial
	begin
		int lastFrame;
		int endCycle;
		int writeIdx;
		int checkIdx;
		int posFrame;
		int posY;
		int acceptY;
		int pix;
		int px;
		int py;
		writeValid = 1'b0;
		writeData = '0;
		reset = 1'b1;
		writeIdx = 0;
		checkIdx = 0;
		loadVectors(lastFrame);
		cycleLimit = (lastFrame + 3) * FRAME_CYCLES; // Test frames plus two
		endCycle = (lastFrame + 1) * FRAME_CYCLES + `PIPE_DEPTH;

		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		// Reset state of the outputs
		checkSync(vgaOut, 1'b1, 1'b1);
		checkColor(vgaOut, 12'h000, 0, 0);
		checkReady(writeReady, 1'b0);

		while (cycle < endCycle)
		begin
			posFrame = cycle / FRAME_CYCLES;
			// Offer next write once its frame starts, held until taken
			if (!writeValid && (writeIdx < writes.size()) &&
				(posFrame >= int'(writes[writeIdx].frame)))
			begin
				writeValid = 1'b1;
				writeData = writes[writeIdx].write;
			end
			acceptY = (cycle / `H_TOTAL) % `V_TOTAL; // Line seen by the coming edge

			@(negedge CLK);
			cycle = cycle + 1;

			// Taken on the edge just passed if that line was in vertical blank
			if (writeValid && (acceptY >= `V_VISIBLE))
			begin
				writeValid = 1'b0;
				writeData = '0;
				writeIdx = writeIdx + 1;
			end

			posY = (cycle / `H_TOTAL) % `V_TOTAL;
			checkReady(writeReady, posY >= `V_VISIBLE); // Ready only in vertical blank

			if (cycle < `PIPE_DEPTH)
			begin
				checkSync(vgaOut, 1'b1, 1'b1); // Pipeline still holds reset values
				checkColor(vgaOut, 12'h000, 0, 0);
			end
			else
			begin
				pix = cycle - `PIPE_DEPTH; // Pixel now at the output
				px = pix % `H_TOTAL;
				py = (pix / `H_TOTAL) % `V_TOTAL;
				checkSync(vgaOut,
					!((px >= `H_VISIBLE + `H_FRONT) && (px < `H_VISIBLE + `H_FRONT + `H_SYNC)),
					!((py >= `V_VISIBLE + `V_FRONT) && (py < `V_VISIBLE + `V_FRONT + `V_SYNC)));
				if ((checkIdx < checks.size()) &&
					(pix / FRAME_CYCLES == int'(checks[checkIdx].frame)) &&
					(px == int'(checks[checkIdx].x)) && (py == int'(checks[checkIdx].y)))
				begin
					checkColor(vgaOut, checks[checkIdx].color, px, py);
					checkIdx = checkIdx + 1;
				end
			end
		end

		// Every write taken and every listed pixel seen
		if ((writeIdx != writes.size()) || (checkIdx != checks.size()))
		begin
			$display("Run ended with %0d of %0d writes accepted and %0d of %0d pixels checked",
				writeIdx, writes.size(), checkIdx, checks.size());
			failNow();
		end
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verification/clockDisplay_golden.txt */
// Hex columns: kind frame a b c; kind 1 write (a field code, b BCD value), kind 2 check
// (a x, b y, c expected color), kind 0 ends; checks in scan order, y then x
1 0 3 12 0 // hour 12
1 0 8 A5 0 // timer second, tens nibble A
1 0 9 1 0 // alarm on
2 0 0BF 040 FF0 // slash corner (191,64)
2 0 10A 04A 000 // off the slash line (266,74)
2 0 0B4 056 FF0 // slash (180,86)
2 0 190 064 00F // divider (400,100)
2 0 2BC 064 000 // right blanking (700,100)
2 0 10A 06B FF0 // second slash (266,107)
2 0 06F 0C2 0F0 // hour tens 0 seg a (111,194)
2 0 0AF 0D4 FF0 // colon dot (175,212)
2 0 0AF 0DE 000 // between dots (175,222)
2 0 06F 0DF 000 // 0 has no seg g (111,223)
2 0 1CC 190 000 // alarm still off (460,400)
2 0 064 1F4 000 // bottom blanking (100,500)
1 1 9 0 0 // alarm off
2 1 06F 0C2 000 // 1 has no seg a (111,194)
2 1 062 0CA 000 // 1 has no seg f (98,202)
2 1 07C 0CA 0F0 // 1 seg b (124,202)
2 1 082 0CA 000 // 2 has no seg f (130,202)
2 1 08F 0DF 0F0 // 2 seg g (143,223)
2 1 082 0ED 0F0 // 2 seg e (130,237)
2 1 09C 0ED 000 // 2 has no seg c (156,237)
2 1 12F 142 000 // nibble A blank, seg a spot (303,322)
2 1 14F 142 0F0 // 5 seg a (335,322)
2 1 15C 14A 000 // 5 has no seg b (348,330)
2 1 12F 15F 000 // nibble A blank, seg g spot (303,351)
2 1 15C 16D 0F0 // 5 seg c (348,365)
2 1 1C0 180 F00 // alarm box corner (448,384)
2 1 1CC 190 F00 // alarm box (460,400)
2 1 1E0 190 000 // right of box (480,400)
2 2 07C 0CA 0F0 // hour still 12 (124,202)
2 2 1C0 180 000 // alarm cleared (448,384)
2 2 1CC 190 000 // alarm cleared (460,400)
0 0 0 0 0

/* tb.f */
+incdir+hdl
hdl/clockDisplayPkg.sv
hdl/vgaTiming.sv
hdl/clockRegs.sv
hdl/screenLayout.sv
hdl/sevenSegGlyph.sv
hdl/pixelMixer.sv
hdl/clockDisplay.sv
verification/clockDisplayTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= clockDisplayTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
